//--- design/address_mapper.sv
`timescale 1ns/1ps

module address_mapper (
    input  machine_pkg::machine_t machine,
    input  machine_pkg::paging_t  paging,
    input  logic [15:0]           addr,
    output logic [18:0]           phys,
    output logic                  is_rom
);
    import machine_pkg::*;

    logic [1:0] slot;
    logic       allram;
    logic [2:0] rom_bank;
    logic [2:0] normal_bank;
    logic [2:0] allram_bank;
    logic [2:0] ram_bank;

    assign slot = addr[15:14];

    // special mode from 1ffd, never on 48k.
    assign allram = paging.p1ffd[0] && (machine != MACHINE_S48);

    assign is_rom = (slot == 2'd0) && !allram;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // rom bank.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        if (machine == MACHINE_S48) begin
            rom_bank = ROM_BANK_S48;
        end else if (machine == MACHINE_S3) begin
            rom_bank = {1'b1, paging.p1ffd[2], paging.rompage}; // 4..7.
        end else begin
            rom_bank = {2'b00, paging.rompage};
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ram bank.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        case (slot)
            2'd1:    normal_bank = BANK_SLOT1;
            2'd2:    normal_bank = BANK_SLOT2;
            // ext flips the top bank bit.
            2'd3:    normal_bank = {paging.rampage[2] ^ paging.ext, paging.rampage[1:0]};
            default: normal_bank = 3'd0; // rom slot, not used.
        endcase
    end

    // four fixed layouts picked by 1ffd[2:1].
    always_comb begin
        case (paging.p1ffd[2:1])
            2'b00: allram_bank = {1'b0, slot};               // 0 1 2 3.
            2'b01: allram_bank = {1'b1, slot};               // 4 5 6 7.
            2'b10: begin
                if (slot == 2'd3) begin
                    allram_bank = 3'd3;                      // 4 5 6 3.
                end else begin
                    allram_bank = {1'b1, slot};
                end
            end
            default: begin
                if (slot == 2'd3) begin
                    allram_bank = 3'd3;                      // 4 7 6 3.
                end else if (slot == 2'd1) begin
                    allram_bank = 3'd7;
                end else begin
                    allram_bank = {1'b1, slot};
                end
            end
        endcase
    end

    assign ram_bank = allram ? allram_bank : normal_bank;

    assign phys = is_rom ? {REGION_ROM, rom_bank, addr[13:0]}
                         : {REGION_RAM, ram_bank, addr[13:0]};

endmodule

//--- design/bus_pkg.sv
package bus_pkg;

    localparam int SRAM_AW = 19;
    localparam int PAGE_AW = 14; // offset inside one 16k bank.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // cpu and video links.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [1:0] {
        OP_MEM_RD = 2'd0,
        OP_MEM_WR = 2'd1,
        OP_IO_WR  = 2'd2
    } cpu_op_t;

    typedef struct packed {
        cpu_op_t     op;
        logic [15:0] addr;
        logic [7:0]  wdata;
    } cpu_req_t;

    typedef struct packed {
        logic [7:0] rdata;
    } cpu_rsp_t;

    typedef struct packed {
        logic [PAGE_AW-1:0] addr; // offset in screen bank.
    } vid_req_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sram side.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic [SRAM_AW-1:0] addr;
        logic [7:0]         wdata;
        logic               rd;
        logic               wr;
    } sram_cmd_t;

    // owner of a read in flight.
    typedef enum logic [1:0] {
        SRC_NONE = 2'd0,
        SRC_CPU  = 2'd1,
        SRC_VID  = 2'd2
    } src_t;

endpackage

//--- design/machine_pkg.sv
package machine_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // machine kinds.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [1:0] {
        MACHINE_S48  = 2'd0,
        MACHINE_S128 = 2'd1,
        MACHINE_S3   = 2'd2
    } machine_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // paging state.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic [2:0] rampage;    // bank at c000.
        logic       rompage;
        logic       screenpage; // bank 5 or bank 7.
        logic       lock;       // set once, cleared by reset only.
        logic [2:0] p1ffd;      // allram, config, rom high bit.
        logic       ext;        // dffd bit 0.
    } paging_t;

    // full 16 bit port decode.
    localparam logic [15:0] PORT_7FFD = 16'h7ffd;
    localparam logic [15:0] PORT_1FFD = 16'h1ffd;
    localparam logic [15:0] PORT_DFFD = 16'hdffd;

    localparam logic [2:0] ROM_BANK_S48 = 3'd3;

    // sram region tags, top two address bits.
    localparam logic [1:0] REGION_ROM = 2'b00;
    localparam logic [1:0] REGION_RAM = 2'b11;

    // fixed ram banks in normal mode.
    localparam logic [2:0] BANK_SLOT1 = 3'd5;
    localparam logic [2:0] BANK_SLOT2 = 3'd2;

endpackage

//--- design/memcontrol.sv
`timescale 1ns/1ps

module memcontrol (
    input  logic               clk28,
    input  logic               rst_n,
    input  bus_pkg::cpu_req_t  cpu_req,
    input  logic               cpu_valid,
    output logic               cpu_ready,
    input  bus_pkg::vid_req_t  vid_req,
    input  logic               vid_valid,
    output logic               vid_ready,
    input  logic               screenpage,
    input  logic [18:0]        phys,
    input  logic               is_rom,
    output logic               io_wr,
    output bus_pkg::sram_cmd_t sram_cmd,
    input  logic [7:0]         sram_rdata,
    output bus_pkg::cpu_rsp_t  cpu_rsp,
    output logic               cpu_rsp_valid,
    output logic [7:0]         vid_rdata,
    output logic               vid_rsp_valid
);
    import machine_pkg::*;
    import bus_pkg::*;

    logic        cpu_acc;
    logic        rd_accept;
    logic        cmd_rd;
    logic        cmd_wr;
    logic [18:0] cmd_addr;
    logic [7:0]  cmd_wdata;
    src_t        src_s1;   // aligned with sram command.
    src_t        src_s2;   // aligned with sram_rdata.

    // video always wins.
    assign vid_ready = vid_valid;
    assign cpu_ready = !vid_valid;
    assign cpu_acc   = cpu_valid && cpu_ready;

    assign io_wr     = cpu_acc && (cpu_req.op == OP_IO_WR);
    assign rd_accept = vid_valid || (cpu_acc && (cpu_req.op == OP_MEM_RD));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // command register.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk28) begin
        if (!rst_n) begin
            cmd_rd <= 1'b0;
            cmd_wr <= 1'b0;
            src_s1 <= SRC_NONE;
            src_s2 <= SRC_NONE;
        end else begin
            cmd_rd <= rd_accept;
            cmd_wr <= !vid_valid && cpu_acc && (cpu_req.op == OP_MEM_WR) && !is_rom;
            src_s1 <= vid_valid ? SRC_VID : (rd_accept ? SRC_CPU : SRC_NONE);
            src_s2 <= src_s1;
        end
    end

    always_ff @(posedge clk28) begin
        if (vid_valid) begin
            cmd_addr <= {REGION_RAM, 1'b1, screenpage, 1'b1, vid_req.addr}; // bank 5 or 7.
        end else begin
            cmd_addr <= phys;
        end
        cmd_wdata <= cpu_req.wdata;
    end

    assign sram_cmd = '{addr: cmd_addr, wdata: cmd_wdata, rd: cmd_rd, wr: cmd_wr};

    // returning byte goes to its owner.
    assign cpu_rsp.rdata = sram_rdata;
    assign vid_rdata     = sram_rdata;
    assign cpu_rsp_valid = (src_s2 == SRC_CPU);
    assign vid_rsp_valid = (src_s2 == SRC_VID);

    a_rd_wr_excl: assert property (
        @(posedge clk28) disable iff (!rst_n) !(sram_cmd.rd && sram_cmd.wr)
    );

    // every response traces back to a read accepted two cycles before.
    a_rsp_has_read: assert property (
        @(posedge clk28) disable iff (!rst_n)
        (cpu_rsp_valid || vid_rsp_valid) |-> $past(rd_accept, 2)
    );

endmodule

//--- design/memory_subsystem.sv
`timescale 1ns/1ps

module memory_subsystem (
    input  logic                  clk28,
    input  logic                  rst_n,
    input  machine_pkg::machine_t machine,
    input  bus_pkg::cpu_req_t     cpu_req,
    input  logic                  cpu_valid,
    output logic                  cpu_ready,
    input  bus_pkg::vid_req_t     vid_req,
    input  logic                  vid_valid,
    output logic                  vid_ready,
    output bus_pkg::cpu_rsp_t     cpu_rsp,
    output logic                  cpu_rsp_valid,
    output logic [7:0]            vid_rdata,
    output logic                  vid_rsp_valid,
    output bus_pkg::sram_cmd_t    sram_cmd,
    input  logic [7:0]            sram_rdata
);
    import machine_pkg::*;

    paging_t     paging;
    logic [18:0] phys;
    logic        is_rom;
    logic        io_wr;

    page_ports i_page_ports (
        .clk28  (clk28),
        .rst_n  (rst_n),
        .machine(machine),
        .io_wr  (io_wr),
        .io_req (cpu_req),
        .paging (paging)
    );

    // translation is combinational on the live request.
    address_mapper i_address_mapper (
        .machine(machine),
        .paging (paging),
        .addr   (cpu_req.addr),
        .phys   (phys),
        .is_rom (is_rom)
    );

    memcontrol i_memcontrol (
        .clk28        (clk28),
        .rst_n        (rst_n),
        .cpu_req      (cpu_req),
        .cpu_valid    (cpu_valid),
        .cpu_ready    (cpu_ready),
        .vid_req      (vid_req),
        .vid_valid    (vid_valid),
        .vid_ready    (vid_ready),
        .screenpage   (paging.screenpage),
        .phys         (phys),
        .is_rom       (is_rom),
        .io_wr        (io_wr),
        .sram_cmd     (sram_cmd),
        .sram_rdata   (sram_rdata),
        .cpu_rsp      (cpu_rsp),
        .cpu_rsp_valid(cpu_rsp_valid),
        .vid_rdata    (vid_rdata),
        .vid_rsp_valid(vid_rsp_valid)
    );

endmodule

//--- design/page_ports.sv
`timescale 1ns/1ps

module page_ports (
    input  logic                  clk28,
    input  logic                  rst_n,
    input  machine_pkg::machine_t machine,
    input  logic                  io_wr,
    input  bus_pkg::cpu_req_t     io_req,
    output machine_pkg::paging_t  paging
);
    import machine_pkg::*;

    logic ports_on;
    logic hit_7ffd;
    logic hit_1ffd;
    logic hit_dffd;

    // 48k has no paging hardware.
    assign ports_on = (machine != MACHINE_S48);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // port decode.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign hit_7ffd = io_wr && ports_on && !paging.lock
                      && (io_req.addr == PORT_7FFD);

    // 1ffd exists on +3 only.
    assign hit_1ffd = io_wr && (machine == MACHINE_S3) && !paging.lock
                      && (io_req.addr == PORT_1FFD);

    assign hit_dffd = io_wr && ports_on
                      && (io_req.addr == PORT_DFFD); // lock does not apply.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // paging registers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk28) begin
        if (!rst_n) begin
            paging <= '0;
        end else begin
            if (hit_7ffd) begin
                paging.rampage    <= io_req.wdata[2:0];
                paging.screenpage <= io_req.wdata[3];
                paging.rompage    <= io_req.wdata[4];
                paging.lock       <= io_req.wdata[5];
            end
            if (hit_1ffd) begin
                paging.p1ffd <= io_req.wdata[2:0];
            end
            if (hit_dffd) begin
                paging.ext <= io_req.wdata[0];
            end
        end
    end

    // lock may only drop on the edge after reset was seen.
    a_lock_sticky: assert property (
        @(posedge clk28) $fell(paging.lock) |-> !$past(rst_n)
    );

    // a locked machine keeps its 7ffd page.
    a_locked_rampage: assert property (
        @(posedge clk28) disable iff (!rst_n)
        $past(paging.lock) && $past(rst_n) |-> $stable(paging.rampage)
    );

endmodule

//--- run.sh
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_memory_subsystem \
    -f verilog.f -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
    exit 1
fi

//--- test/sram_model.sv
`timescale 1ns/1ps

module sram_model (
    input  logic               clk28,
    input  bus_pkg::sram_cmd_t cmd,
    output logic [7:0]         rdata
);
    import bus_pkg::*;

    logic [7:0] mem [0:(1 << SRAM_AW) - 1];

    // power-up contents, distinct per bank and offset.
    initial begin
        logic [SRAM_AW-1:0] a;
        for (int i = 0; i < (1 << SRAM_AW); i++) begin
            a = SRAM_AW'(i);
            mem[i] <= a[7:0] ^ a[15:8] ^ {3'b000, a[18:14]} ^ 8'h5a;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // synchronous port, registered read.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(posedge clk28) begin
        if (cmd.wr) begin
            mem[cmd.addr] <= cmd.wdata;
        end
        if (cmd.rd) begin
            rdata <= mem[cmd.addr]; // one cycle latency.
        end
    end

endmodule

//--- test/tb_memory_subsystem.sv
`timescale 1ns/1ps

module tb_memory_subsystem;
    import machine_pkg::*;
    import bus_pkg::*;

    localparam int N_RAM = 64;
    localparam int N_MIX = 150;
    localparam int N_VID = 200;
    localparam int N_XFERS = 2 * N_RAM + N_MIX + N_VID + 150; // directed tests add ~150.
    localparam int WATCHDOG_CYCLES = N_XFERS * 10 + 1000;

    logic        clk28;
    logic        rst_n;
    machine_t    machine;
    cpu_req_t    cpu_req;
    logic        cpu_valid;
    logic        cpu_ready;
    vid_req_t    vid_req;
    logic        vid_valid;
    logic        vid_ready;
    cpu_rsp_t    cpu_rsp;
    logic        cpu_rsp_valid;
    logic [7:0]  vid_rdata;
    logic        vid_rsp_valid;
    sram_cmd_t   sram_cmd;
    logic [7:0]  sram_rdata;

    logic [7:0]  shadow [0:(1 << 19) - 1];
    paging_t     ref_pg;
    cpu_rsp_t    exp_cpu [$];
    int unsigned exp_cpu_cyc [$];
    logic [7:0]  exp_vid [$];
    logic [2:0]  allram_map [4][4] = '{'{3'd0, 3'd1, 3'd2, 3'd3}, '{3'd4, 3'd5, 3'd6, 3'd7},
                                       '{3'd4, 3'd5, 3'd6, 3'd3}, '{3'd4, 3'd7, 3'd6, 3'd3}};
    logic [31:0] rng = 32'h0ecb9b16;
    logic [31:0] vrng = ~32'h0ecb9b16; // separate stream for the video driver.
    int unsigned cycle = 0;
    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          test_err_base = 0;
    string       cur_test = "reset";

    memory_subsystem i_dut (
        .clk28        (clk28),
        .rst_n        (rst_n),
        .machine      (machine),
        .cpu_req      (cpu_req),
        .cpu_valid    (cpu_valid),
        .cpu_ready    (cpu_ready),
        .vid_req      (vid_req),
        .vid_valid    (vid_valid),
        .vid_ready    (vid_ready),
        .cpu_rsp      (cpu_rsp),
        .cpu_rsp_valid(cpu_rsp_valid),
        .vid_rdata    (vid_rdata),
        .vid_rsp_valid(vid_rsp_valid),
        .sram_cmd     (sram_cmd),
        .sram_rdata   (sram_rdata)
    );

    sram_model i_sram (
        .clk28(clk28),
        .cmd  (sram_cmd),
        .rdata(sram_rdata)
    );

    initial begin
        clk28 = 1'b0;
        forever #20 clk28 = ~clk28;
    end

    always @(posedge clk28) cycle <= cycle + 1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] rnd();
        rng = lcg_next(rng);
        return rng;
    endfunction

    function automatic logic [7:0] fill_byte(input logic [18:0] a);
        return a[7:0] ^ a[15:8] ^ {3'b000, a[18:14]} ^ 8'h5a;
    endfunction

    function automatic logic [18:0] ref_map(input machine_t m, input paging_t p,
                                            input logic [15:0] a, output logic rom);
        logic [1:0] slot;
        logic       allram;
        logic [2:0] bank;
        slot = a[15:14];
        allram = (m != MACHINE_S48) && p.p1ffd[0];
        rom = (slot == 2'd0) && !allram;
        if (rom) begin
            if (m == MACHINE_S48) begin
                bank = ROM_BANK_S48;
            end else if (m == MACHINE_S128) begin
                bank = {2'b00, p.rompage};
            end else begin
                bank = 3'd4 + {1'b0, p.p1ffd[2], 1'b0} + {2'b00, p.rompage};
            end
            return {2'b00, bank, a[13:0]};
        end
        if (allram) begin
            bank = allram_map[p.p1ffd[2:1]][slot];
        end else if (slot == 2'd1) begin
            bank = 3'd5;
        end else if (slot == 2'd2) begin
            bank = 3'd2;
        end else begin
            bank = p.rampage ^ {p.ext, 2'b00};
        end
        return {2'b11, bank, a[13:0]};
    endfunction

    task automatic ref_port_write(input logic [15:0] addr, input logic [7:0] data);
        if (machine != MACHINE_S48) begin
            if (addr == PORT_7FFD && !ref_pg.lock) begin
                ref_pg.rampage    = data[2:0];
                ref_pg.screenpage = data[3];
                ref_pg.rompage    = data[4];
                ref_pg.lock       = data[5];
            end else if (addr == PORT_1FFD && machine == MACHINE_S3 && !ref_pg.lock) begin
                ref_pg.p1ffd = data[2:0];
            end else if (addr == PORT_DFFD) begin
                ref_pg.ext = data[0];
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_cpu_rsp(input string name, input cpu_rsp_t exp, input cpu_rsp_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s: expected %02h, actual %02h", name, exp.rdata, act.rdata);
        end
    endtask

    task automatic check_video(input string name, input logic [7:0] exp, input logic [7:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s: video expected %02h, actual %02h", name, exp, act);
        end
    endtask

    always @(negedge clk28) begin
        if (rst_n && cpu_rsp_valid) begin
            if (exp_cpu.size() == 0) begin
                errors++;
                $display("%s: cpu response arrived with no read outstanding", cur_test);
            end else begin
                if (cycle != exp_cpu_cyc[0] + 2) begin
                    errors++;
                    $display("%s: cpu response in cycle %0d for a read accepted in cycle %0d",
                             cur_test, cycle, exp_cpu_cyc[0]);
                end
                check_cpu_rsp(cur_test, exp_cpu.pop_front(), cpu_rsp);
                void'(exp_cpu_cyc.pop_front());
            end
        end
        if (rst_n && vid_rsp_valid) begin
            if (exp_vid.size() == 0) begin
                errors++;
                $display("%s: video response arrived with no fetch outstanding", cur_test);
            end else begin
                check_video(cur_test, exp_vid.pop_front(), vid_rdata);
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk28);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic reset_dut(input machine_t m);
        @(negedge clk28);
        rst_n = 1'b0;
        machine = m;
        cpu_valid = 1'b0;
        vid_valid = 1'b0;
        repeat (16) @(negedge clk28);
        rst_n = 1'b1;
        ref_pg = '0;
    endtask

    // request stays up until accepted, the ref model follows on that edge.
    task automatic cpu_xfer(input cpu_op_t op, input logic [15:0] addr, input logic [7:0] wdata);
        logic [18:0] phys;
        logic        rom;
        @(negedge clk28);
        cpu_req.op    = op;
        cpu_req.addr  = addr;
        cpu_req.wdata = wdata;
        cpu_valid     = 1'b1;
        @(posedge clk28);
        while (!cpu_ready) @(posedge clk28);
        phys = ref_map(machine, ref_pg, addr, rom);
        case (op)
            OP_MEM_RD: begin
                exp_cpu.push_back(cpu_rsp_t'(shadow[phys]));
                exp_cpu_cyc.push_back(cycle);
            end
            OP_MEM_WR: begin
                if (!rom) shadow[phys] = wdata; // rom writes vanish.
            end
            default: ref_port_write(addr, wdata);
        endcase
    endtask

    task automatic cpu_release();
        @(negedge clk28);
        cpu_valid = 1'b0;
    endtask

    task automatic drain();
        cpu_release();
        while (exp_cpu.size() != 0 || exp_vid.size() != 0) @(posedge clk28);
        repeat (3) @(posedge clk28);
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        test_err_base = errors;
    endtask

    task automatic finish_test();
        drain();
        tests_run++;
        if (errors == test_err_base) begin
            $display("test %s: passed", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", cur_test, errors - test_err_base);
        end
    endtask

    task automatic cpu_traffic(input int n);
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            r = rnd();
            if (r[3:0] == 4'd0) begin
                cpu_xfer(OP_IO_WR, PORT_7FFD, {3'b000, r[9], r[8], r[6:4]});
            end else if (r[3]) begin
                cpu_xfer(OP_MEM_WR, r[31:16], r[15:8]);
            end else begin
                cpu_xfer(OP_MEM_RD, r[31:16], 8'h00);
            end
        end
        cpu_release();
    endtask

    task automatic video_traffic(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk28);
            vrng = lcg_next(vrng);
            vid_valid = vrng[31];
            vid_req.addr = vrng[21:8];
            @(posedge clk28);
            if (vid_ready !== vid_valid || cpu_ready !== !vid_valid) begin
                errors++;
                $display("%s: ready signals do not follow video priority", cur_test);
            end
            if (vid_valid) begin
                exp_vid.push_back(shadow[{2'b11, 1'b1, ref_pg.screenpage, 1'b1, vid_req.addr}]);
            end
        end
        @(negedge clk28);
        vid_valid = 1'b0;
    endtask

    initial begin
        logic [15:0] waddr [N_RAM];
        logic [15:0] a;
        rst_n = 1'b0;
        machine = MACHINE_S128;
        cpu_valid = 1'b0;
        cpu_req = '0;
        vid_valid = 1'b0;
        vid_req = '0;
        for (int i = 0; i < (1 << 19); i++) begin
            shadow[i] = fill_byte(19'(i));
        end

        start_test("ram_rw");
        reset_dut(MACHINE_S128);
        for (int i = 0; i < N_RAM; i++) begin
            waddr[i] = 16'(rnd());
            cpu_xfer(OP_MEM_WR, waddr[i], 8'(rnd()));
        end
        for (int i = 0; i < N_RAM; i++) begin
            cpu_xfer(OP_MEM_RD, waddr[i], 8'h00);
        end
        finish_test();

        start_test("paging_7ffd");
        for (int b = 0; b < 8; b++) begin
            a = 16'hc000 | {2'b00, 14'(rnd())};
            cpu_xfer(OP_IO_WR, PORT_7FFD, {3'b000, b[0], 1'b0, b[2:0]});
            cpu_xfer(OP_MEM_RD, a, 8'h00);
            cpu_xfer(OP_MEM_WR, a, 8'(rnd()));
            cpu_xfer(OP_MEM_RD, a, 8'h00);
            cpu_xfer(OP_MEM_RD, {2'b00, 14'(rnd())}, 8'h00); // rom page.
        end
        a = {2'b00, 14'(rnd())};
        cpu_xfer(OP_IO_WR, PORT_7FFD, 8'h05);
        cpu_xfer(OP_MEM_WR, 16'hc000 | a, 8'(rnd()));
        cpu_xfer(OP_MEM_RD, 16'h4000 | a, 8'h00);
        a = {2'b00, 14'(rnd())};
        cpu_xfer(OP_IO_WR, PORT_DFFD, 8'h01);
        cpu_xfer(OP_IO_WR, PORT_7FFD, 8'h01); // 1 with ext is bank 5.
        cpu_xfer(OP_MEM_WR, 16'hc000 | a, 8'(rnd()));
        cpu_xfer(OP_MEM_RD, 16'h4000 | a, 8'h00);
        cpu_xfer(OP_IO_WR, PORT_DFFD, 8'h00);
        cpu_xfer(OP_MEM_RD, 16'hc000 | a, 8'h00);
        finish_test();

        start_test("lock");
        reset_dut(MACHINE_S3);
        a = {2'b00, 14'(rnd())};
        cpu_xfer(OP_IO_WR, PORT_7FFD, 8'h23);
        cpu_xfer(OP_IO_WR, PORT_7FFD, 8'h06);
        cpu_xfer(OP_IO_WR, PORT_1FFD, 8'h01);
        cpu_xfer(OP_MEM_RD, 16'hc000 | a, 8'h00);
        cpu_xfer(OP_MEM_RD, a, 8'h00);
        cpu_xfer(OP_IO_WR, PORT_DFFD, 8'h01);
        cpu_xfer(OP_MEM_RD, 16'hc000 | a, 8'h00);
        drain();
        reset_dut(MACHINE_S48);
        cpu_xfer(OP_IO_WR, PORT_7FFD, 8'h07);
        cpu_xfer(OP_IO_WR, PORT_1FFD, 8'h05);
        cpu_xfer(OP_IO_WR, PORT_DFFD, 8'h01);
        cpu_xfer(OP_MEM_RD, 16'hc000 | a, 8'h00);
        cpu_xfer(OP_MEM_RD, a, 8'h00);
        cpu_xfer(OP_MEM_WR, a, 8'(rnd()));
        cpu_xfer(OP_MEM_RD, a, 8'h00);
        finish_test();

        start_test("plus3_allram");
        reset_dut(MACHINE_S3);
        for (int cfg = 0; cfg < 4; cfg++) begin
            cpu_xfer(OP_IO_WR, PORT_1FFD, {5'b00000, cfg[1:0], 1'b1});
            for (int s = 0; s < 4; s++) begin
                a = {s[1:0], 14'(rnd())};
                cpu_xfer(OP_MEM_RD, a, 8'h00);
                cpu_xfer(OP_MEM_WR, a, 8'(rnd()));
                cpu_xfer(OP_MEM_RD, a, 8'h00);
            end
        end
        // normal mode, every rom bank.
        for (int c = 0; c < 4; c++) begin
            cpu_xfer(OP_IO_WR, PORT_1FFD, {5'b00000, c[1], 2'b00});
            cpu_xfer(OP_IO_WR, PORT_7FFD, {3'b000, c[0], 4'b0000});
            a = {2'b00, 14'(rnd())};
            cpu_xfer(OP_MEM_RD, a, 8'h00);
            cpu_xfer(OP_MEM_WR, a, 8'(rnd()));
            cpu_xfer(OP_MEM_RD, a, 8'h00);
        end
        finish_test();

        start_test("video_mix");
        reset_dut(MACHINE_S128);
        fork
            video_traffic(N_VID);
            cpu_traffic(N_MIX);
        join
        finish_test();

        $display("tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- verilog.f
design/machine_pkg.sv
design/bus_pkg.sv
design/page_ports.sv
design/address_mapper.sv
design/memcontrol.sv
design/memory_subsystem.sv
test/sram_model.sv
test/tb_memory_subsystem.sv
